// File: rtl/link_cal_pkg.sv
// link sizes of the receive-side calibration controller
// calibration timing constants and the three test codes

package link_cal_pkg;

   // link shape
   localparam int link_channels = 4;
   localparam int channel_width = 8;

   // enough bits to name any bit position of a word
   localparam int slip_width    = 3;

   // index of the last test, tests run from 0 up to this value
   localparam int tests            = 2;
   localparam int test_index_width = 2;

   // prepare phase length after start and after each test advance
   localparam int prepare_cycles = 8;

   // passing set must hold still this long before a partial pass counts
   localparam int timeout_cycles = 16;

   // consecutive good words before a checker reports pass
   localparam int match_run = 4;

   // test codes
   // alive: every word is all ones
   localparam logic [test_index_width-1:0] test_alive = 2'd0;

   // align: a single stable hot bit gives the word boundary
   localparam logic [test_index_width-1:0] test_align = 2'd1;

   // count: counting pattern once the slip is undone
   localparam logic [test_index_width-1:0] test_count = 2'd2;

endpackage

// File: rtl/cal_wait_cycles.sv
// restartable down-counter
// reports ready once cycles_p cycles have passed since the last activation

`timescale 1ns/1ps

module cal_wait_cycles
#(
   parameter int cycles_p = 8
)
(
   input  logic clk_i,
   input  logic reset_i,
   input  logic activate_i,
   output logic ready_r_o
);

   // wide enough to hold cycles_p itself
   localparam int count_width = $clog2(cycles_p + 1);

   logic [count_width-1:0] count_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         // idle counter sits at zero, so ready right after reset
         count_r <= '0;
      end
      else if (activate_i)
      begin
         // reload also restarts a wait already in progress
         count_r <= count_width'(cycles_p);
      end
      else if (count_r != '0)
      begin
         count_r <= count_r - 1'b1;
      end
   end

   // high from the cycle the count reaches zero
   assign ready_r_o = (count_r == '0);

endmodule

// File: rtl/cal_channel_checker.sv
// per-channel judge of received words against the current calibration test
// alignment search gives a slip candidate, a match-run counter gives pass

`timescale 1ns/1ps

module cal_channel_checker
   import link_cal_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic [channel_width-1:0]    data_i,
   input  logic [test_index_width-1:0] test_index_i,
   input  logic                        prepare_i,
   input  logic [slip_width-1:0]       bit_slip_i,
   output logic                        pass_o,
   output logic [slip_width-1:0]       slip_candidate_o
);

   localparam int run_width = $clog2(match_run + 1);

   logic [channel_width-1:0]   prev_word_r;
   logic [2*channel_width-1:0] doubled;
   logic [channel_width-1:0]   rotated;
   logic                       one_hot;
   logic                       align_hit;
   logic [slip_width-1:0]      hot_pos;
   logic                       match;
   logic [run_width-1:0]       run_r;

   // rotate right by the latched slip, via a doubled word shifted down
   assign doubled = {data_i, data_i} >> bit_slip_i;
   assign rotated = doubled[channel_width-1:0];

   // exactly one bit set: non-zero and clearing the lowest bit leaves nothing
   assign one_hot = (data_i != '0) && ((data_i & (data_i - 1'b1)) == '0);

   // the hot bit must sit where it sat in the previous word
   assign align_hit = one_hot && (data_i == prev_word_r);

   // position of the set bit, only meaningful when one_hot
   always_comb
   begin
      hot_pos = '0;
      for (int i = 0; i < channel_width; i++)
      begin
         if (data_i[i])
         begin
            hot_pos = slip_width'(i);
         end
      end
   end

   // no stable hot bit means no alignment found yet
   assign slip_candidate_o = align_hit ? hot_pos : '0;

   // rule of the current test
   always_comb
   begin
      case (test_index_i)
         test_alive: match = (data_i == '1);
         test_align: match = align_hit;
         // compare holds 8 bits, so the increment wraps at 256
         test_count: match = (rotated == prev_word_r + 1'b1);
         default:    match = 1'b0;
      endcase
   end

   // previous word, kept in the same frame the current rule compares in
   always_ff @(posedge clk_i)
   begin
      if (test_index_i == test_count)
      begin
         prev_word_r <= rotated;
      end
      else
      begin
         prev_word_r <= data_i;
      end
   end

   // consecutive matches, saturating at match_run
   always_ff @(posedge clk_i)
   begin
      if (reset_i || prepare_i)
      begin
         run_r <= '0;
      end
      else if (!match)
      begin
         run_r <= '0;
      end
      else if (run_r != run_width'(match_run))
      begin
         run_r <= run_r + 1'b1;
      end
   end

   assign pass_o = (run_r == run_width'(match_run));

endmodule

// File: rtl/cal_scoreboard.sv
// per-test, per-channel pass record
// cleared on start, only the row of the running test follows the checkers

`timescale 1ns/1ps

module cal_scoreboard
   import link_cal_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        start_i,
   input  logic                        prepare_i,
   input  logic [test_index_width-1:0] test_index_i,
   input  logic [link_channels-1:0]    pass_i,
   output logic [link_channels-1:0]    scoreboard_o [tests+1]
);

   logic [link_channels-1:0] record_r [tests+1];

   always_ff @(posedge clk_i)
   begin
      if (reset_i || start_i)
      begin
         // fresh run, nothing has passed yet
         for (int t = 0; t <= tests; t++)
         begin
            record_r[t] <= '0;
         end
      end
      else if (!prepare_i)
      begin
         // only the running test row moves, finished rows keep their result
         for (int t = 0; t <= tests; t++)
         begin
            if (test_index_i == test_index_width'(t))
            begin
               record_r[t] <= pass_i;
            end
         end
      end
   end

   assign scoreboard_o = record_r;

endmodule

// File: rtl/cal_sequencer.sv
// calibration test sequencer
// prepare and stability waits, done flag, bit-slip latch during the align test

`timescale 1ns/1ps

module cal_sequencer
   import link_cal_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        start_i,
   input  logic [link_channels-1:0]    scoreboard_i [tests+1],
   input  logic [slip_width-1:0]       slip_candidate_i [link_channels],
   output logic [test_index_width-1:0] test_index_o,
   output logic                        prepare_o,
   output logic                        done_o,
   output logic [slip_width-1:0]       bit_slip_o [link_channels]
);

   logic [test_index_width-1:0] test_index_r;
   logic [test_index_width-1:0] test_index_n;
   logic                        done_r;
   logic                        done_n;
   logic                        running_r;
   logic                        running_n;
   logic [link_channels-1:0]    scoreboard_r [tests+1];
   logic [link_channels-1:0]    row_now;
   logic [link_channels-1:0]    row_r;
   logic [slip_width-1:0]       bit_slip_r [link_channels];
   logic                        prep_activate;
   logic                        prep_ready;
   logic                        window_ready;
   logic                        final_test;

   // prepare phase, restarted on start and on every advance
   cal_wait_cycles #(.cycles_p(prepare_cycles)) u_prep_wait
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .activate_i (prep_activate),
      .ready_r_o  (prep_ready)
   );

   // stability window, restarted whenever the passing set moves
   // a channel that keeps toggling keeps this window from ever closing
   cal_wait_cycles #(.cycles_p(timeout_cycles)) u_window_wait
   (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .activate_i (row_now != row_r),
      .ready_r_o  (window_ready)
   );

   assign row_now    = scoreboard_i[test_index_r];
   assign row_r      = scoreboard_r[test_index_r];
   assign final_test = (test_index_r == test_index_width'(tests));

   // next test index, done and run flags
   always_comb
   begin
      test_index_n  = test_index_r;
      done_n        = done_r;
      running_n     = running_r;
      prep_activate = 1'b0;

      if (start_i)
      begin
         // restart from test 0 whatever state we were in
         test_index_n  = '0;
         done_n        = 1'b0;
         running_n     = 1'b1;
         prep_activate = 1'b1;
      end
      else if (running_r && prep_ready)
      begin
         // everyone passed, or a partial set that has settled
         if ((&row_r) || ((|row_r) && window_ready))
         begin
            if (final_test)
            begin
               done_n    = 1'b1;
               running_n = 1'b0;
            end
            else
            begin
               test_index_n  = test_index_r + 1'b1;
               prep_activate = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         test_index_r <= '0;
         done_r       <= 1'b0;
         running_r    <= 1'b0;
         scoreboard_r <= '{default: '0};
      end
      else
      begin
         test_index_r <= test_index_n;
         done_r       <= done_n;
         running_r    <= running_n;
         // decisions look at this copy, one cycle behind the scoreboard
         scoreboard_r <= scoreboard_i;
      end
   end

   // slip amounts follow the checkers only while aligning, then hold
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         bit_slip_r <= '{default: '0};
      end
      else if (test_index_r == test_align)
      begin
         bit_slip_r <= slip_candidate_i;
      end
   end

   assign test_index_o = test_index_r;
   assign prepare_o    = ~prep_ready;
   assign done_o       = done_r;
   assign bit_slip_o   = bit_slip_r;

endmodule

// File: rtl/link_cal_top.sv
// receive-side link calibration controller
// one checker per channel, the pass scoreboard and the test sequencer

`timescale 1ns/1ps

module link_cal_top
   import link_cal_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        start_i,
   input  logic [channel_width-1:0]    link_data_i [link_channels],
   output logic [test_index_width-1:0] test_index_o,
   output logic                        prepare_o,
   output logic                        done_o,
   output logic [slip_width-1:0]       bit_slip_o [link_channels]
);

   logic [test_index_width-1:0] test_index;
   logic                        prepare;
   logic [slip_width-1:0]       bit_slip [link_channels];
   logic [link_channels-1:0]    pass;
   logic [slip_width-1:0]       slip_candidate [link_channels];
   logic [link_channels-1:0]    scoreboard [tests+1];

   // every checker sees the same test and prepare, and its own slip
   for (genvar c = 0; c < link_channels; c++)
   begin : g_channel
      cal_channel_checker u_checker
      (
         .clk_i            (clk_i),
         .reset_i          (reset_i),
         .data_i           (link_data_i[c]),
         .test_index_i     (test_index),
         .prepare_i        (prepare),
         .bit_slip_i       (bit_slip[c]),
         .pass_o           (pass[c]),
         .slip_candidate_o (slip_candidate[c])
      );
   end

   cal_scoreboard u_scoreboard
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (start_i),
      .prepare_i    (prepare),
      .test_index_i (test_index),
      .pass_i       (pass),
      .scoreboard_o (scoreboard)
   );

   cal_sequencer u_sequencer
   (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .start_i          (start_i),
      .scoreboard_i     (scoreboard),
      .slip_candidate_i (slip_candidate),
      .test_index_o     (test_index),
      .prepare_o        (prepare),
      .done_o           (done_o),
      .bit_slip_o       (bit_slip)
   );

   assign test_index_o = test_index;
   assign prepare_o    = prepare;
   assign bit_slip_o   = bit_slip;

endmodule

// File: tests/link_cal_assertions.sv
// concurrent checks on reset state, prepare window, done, test order and slip hold
// bind of the checks into link_cal_top

`timescale 1ns/1ps

module link_cal_assertions
   import link_cal_pkg::*;
(
   input logic                        clk_i,
   input logic                        reset_i,
   input logic                        start_i,
   input logic [test_index_width-1:0] test_index_o,
   input logic                        prepare_o,
   input logic                        done_o,
   input logic [slip_width-1:0]       bit_slip_o [link_channels]
);

   int failures = 0;

   // all slips side by side so they compare as one value
   logic [link_channels*slip_width-1:0] slip_flat;

   always_comb
   begin
      for (int c = 0; c < link_channels; c++)
      begin
         slip_flat[c*slip_width +: slip_width] = bit_slip_o[c];
      end
   end

   reset_quiet: assert property (@(posedge clk_i) reset_i |=> !prepare_o && !done_o)
      else begin $error("prepare_o or done_o active after reset"); failures++; end

   // start loads the prepare counter, high for the whole count then low
   prepare_window: assert property (@(posedge clk_i) disable iff (reset_i)
      start_i |=> prepare_o [*prepare_cycles] ##1 !prepare_o)
      else begin $error("prepare window after start has the wrong length"); failures++; end

   done_on_last: assert property (@(posedge clk_i) disable iff (reset_i)
      done_o |-> test_index_o == test_index_width'(tests))
      else begin $error("done_o high before the last test"); failures++; end

   index_order: assert property (@(posedge clk_i) disable iff (reset_i)
      !start_i |=> test_index_o >= $past(test_index_o))
      else begin $error("test index went back without a start"); failures++; end

   slip_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      test_index_o != test_align |=> $stable(slip_flat))
      else begin $error("bit slip changed outside the align test"); failures++; end

endmodule

bind link_cal_top link_cal_assertions u_assertions
(
   .clk_i        (clk_i),
   .reset_i      (reset_i),
   .start_i      (start_i),
   .test_index_o (test_index_o),
   .prepare_o    (prepare_o),
   .done_o       (done_o),
   .bit_slip_o   (bit_slip_o)
);

// File: tests/link_cal_tb.sv
// testbench for the link calibration controller
// per-channel word generators, six scenarios, per-test lines and closing counts

`timescale 1ns/1ps

module link_cal_tb
   import link_cal_pkg::*;
();

   logic                        clk_i;
   logic                        reset_i;
   logic                        start_i;
   logic [channel_width-1:0]    link_data_i [link_channels];
   logic [test_index_width-1:0] test_index_o;
   logic                        prepare_o;
   logic                        done_o;
   logic [slip_width-1:0]       bit_slip_o [link_channels];

   // per-channel generator setup where count_slip departs from slip only to break test_count
   logic [slip_width-1:0]       slip [link_channels];
   logic [slip_width-1:0]       count_slip [link_channels];
   logic [link_channels-1:0]    dead;
   logic [channel_width-1:0]    count_word = '0;

   integer seed = 75859;
   int     errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     fault_mark = 0;

   link_cal_top u_link_cal_top
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (start_i),
      .link_data_i  (link_data_i),
      .test_index_o (test_index_o),
      .prepare_o    (prepare_o),
      .done_o       (done_o),
      .bit_slip_o   (bit_slip_o)
   );

   initial clk_i = 1'b0;
   always #20 clk_i = ~clk_i;

   function automatic logic [channel_width-1:0] rotate_left(input logic [channel_width-1:0] w,
                                                            input logic [slip_width-1:0] s);
      return (w << s) | (w >> (channel_width - s));
   endfunction

   // transmitter side picks its pattern from the test the DUT is running
   function automatic logic [channel_width-1:0] word_for(input int c);
      if (dead[c])
      begin
         return '0;
      end
      case (test_index_o)
         test_alive: return '1;
         test_align: return channel_width'(1) << slip[c];
         test_count: return rotate_left(count_word, count_slip[c]);
         default:    return '0;
      endcase
   endfunction

   always @(negedge clk_i)
   begin
      count_word = count_word + 1'b1;
      for (int c = 0; c < link_channels; c++)
      begin
         link_data_i[c] = word_for(c);
      end
   end

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual)
      begin
         $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
         errors++;
      end
   endtask

   // value checks here plus the bound assertion failures
   function automatic int fault_total();
      return errors + u_link_cal_top.u_assertions.failures;
   endfunction

   task automatic finish_scenario(input string name);
      tests_run++;
      if (fault_total() == fault_mark)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
      fault_mark = fault_total();
   endtask

   task automatic pulse_start();
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
   endtask

   // settle counts the cycles the count test spends judging words, prepare excluded
   task automatic wait_for_done(output int settle);
      int n;
      n      = 0;
      settle = 0;
      while (!done_o && n < 400)
      begin
         @(negedge clk_i);
         n++;
         if (!done_o && !prepare_o && test_index_o == test_count)
         begin
            settle++;
         end
      end
      if (!done_o)
      begin
         $display("%0t done_o did not rise within 400 cycles", $time);
         errors++;
      end
   endtask

   // a full pass ends the count test within a few register stages
   // while a partial pass first sits out the stability window
   task automatic check_settle(input int settle, input logic through_window);
      if (through_window && settle < timeout_cycles)
      begin
         $display("%0t count test ended after %0d cycles, inside the stability window",
                  $time, settle);
         errors++;
      end
      else if (!through_window && settle >= timeout_cycles)
      begin
         $display("%0t count test took %0d cycles although every channel passed",
                  $time, settle);
         errors++;
      end
   endtask

   task automatic draw_slips();
      logic [31:0] r;
      for (int c = 0; c < link_channels; c++)
      begin
         r             = $random(seed);
         slip[c]       = r[slip_width-1:0];
         count_slip[c] = slip[c];
      end
   endtask

   // a dead channel never finds a hot bit so it latches 0
   task automatic check_slips();
      for (int c = 0; c < link_channels; c++)
      begin
         check_value($sformatf("bit_slip_o[%0d]", c), dead[c] ? 0 : slip[c], bit_slip_o[c]);
      end
   endtask

   initial
   begin
      int n;
      int settle;
      reset_i = 1'b1;
      start_i = 1'b0;
      dead    = '0;
      for (int c = 0; c < link_channels; c++)
      begin
         link_data_i[c] = '0;
         slip[c]        = '0;
         count_slip[c]  = '0;
      end
      repeat (3) @(negedge clk_i);
      reset_i = 1'b0;

      // check idle outputs and then measure the first prepare window
      check_value("prepare_o", 0, prepare_o);
      check_value("done_o", 0, done_o);
      check_value("test_index_o", 0, test_index_o);
      check_slips();
      pulse_start();
      n = 0;
      while (prepare_o && n < 400)
      begin
         n++;
         @(negedge clk_i);
      end
      check_value("prepare_o cycles", prepare_cycles, n);
      finish_scenario("reset and prepare window");

      draw_slips();
      pulse_start();
      wait_for_done(settle);
      check_value("test_index_o", tests, test_index_o);
      check_slips();
      check_settle(settle, 1'b0);
      finish_scenario("all channels healthy");

      // channel 2 stays silent so the rest finish through the stability window
      draw_slips();
      dead = 4'b0100;
      pulse_start();
      wait_for_done(settle);
      check_value("test_index_o", tests, test_index_o);
      check_slips();
      check_settle(settle, 1'b1);
      finish_scenario("one dead channel");

      dead = '1;
      pulse_start();
      n = 0;
      while (n < 300 && !done_o && test_index_o == test_alive)
      begin
         @(negedge clk_i);
         n++;
      end
      check_value("done_o", 0, done_o);
      check_value("test_index_o", 0, test_index_o);
      finish_scenario("all channels dead");

      // channel 1 counts with a slip other than the one it showed while aligning
      draw_slips();
      dead          = '0;
      count_slip[1] = slip[1] + 1'b1;
      pulse_start();
      wait_for_done(settle);
      check_value("test_index_o", tests, test_index_o);
      check_slips();
      check_settle(settle, 1'b1);
      finish_scenario("wrong slip in count test");

      // done_o is still high from the previous run here
      draw_slips();
      pulse_start();
      check_value("done_o", 0, done_o);
      n = 0;
      // let the align test get past its prepare phase before restarting
      while ((test_index_o != test_align || prepare_o) && n < 400)
      begin
         @(negedge clk_i);
         n++;
      end
      check_value("test_index_o", test_align, test_index_o);
      check_value("prepare_o", 0, prepare_o);
      // restart in the middle of the align test
      draw_slips();
      pulse_start();
      check_value("test_index_o", 0, test_index_o);
      check_value("prepare_o", 1, prepare_o);
      wait_for_done(settle);
      check_value("test_index_o", tests, test_index_o);
      check_slips();
      check_settle(settle, 1'b0);
      finish_scenario("restart mid-run");

      $display("tests %0d, passed %0d, failed %0d, value errors %0d, assertion failures %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors,
               u_link_cal_top.u_assertions.failures);
      if (tests_failed == 0 && fault_total() == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: filelist.f
rtl/link_cal_pkg.sv
rtl/cal_wait_cycles.sv
rtl/cal_channel_checker.sv
rtl/cal_scoreboard.sv
rtl/cal_sequencer.sv
rtl/link_cal_top.sv
tests/link_cal_assertions.sv
tests/link_cal_tb.sv

// File: Bender.yml
package:
  name: link_cal

sources:
  # rtl
  - files:
      - rtl/link_cal_pkg.sv
      - rtl/cal_wait_cycles.sv
      - rtl/cal_channel_checker.sv
      - rtl/cal_scoreboard.sv
      - rtl/cal_sequencer.sv
      - rtl/link_cal_top.sv
  # tests
  - target: test
    files:
      - tests/link_cal_assertions.sv
      - tests/link_cal_tb.sv
